// ==== design/decodePkg.sv ====
`default_nettype none

package decodePkg;

    // Field and word widths
    localparam int InstrWidth = 32;
    localparam int XLen = 32;
    localparam int RegIdxWidth = 5;
    localparam int Funct3Width = 3;
    localparam int Funct7Width = 7;
    localparam int OpcodeWidth = 7;
    localparam int AluOpWidth = 5;

    typedef logic [InstrWidth-1:0] instrT;
    typedef logic [XLen-1:0] wordT;
    typedef logic [RegIdxWidth-1:0] regIdxT;
    typedef logic [Funct3Width-1:0] funct3T;
    typedef logic [OpcodeWidth-1:0] opcodeT;

    // RV32 base opcode map, low two bits always 11
    localparam opcodeT OpLui = 7'b0110111;
    localparam opcodeT OpAuipc = 7'b0010111;
    localparam opcodeT OpJal = 7'b1101111;
    localparam opcodeT OpJalr = 7'b1100111;
    localparam opcodeT OpBranch = 7'b1100011;
    localparam opcodeT OpLoad = 7'b0000011;
    localparam opcodeT OpStore = 7'b0100011;
    localparam opcodeT OpImm = 7'b0010011;
    // Shared by base OP and the M extension
    localparam opcodeT OpReg = 7'b0110011;
    localparam opcodeT OpSystem = 7'b1110011;

    // Legal func7 values
    localparam logic [Funct7Width-1:0] Func7Base = 7'b0000000;
    localparam logic [Funct7Width-1:0] Func7Alt = 7'b0100000;
    localparam logic [Funct7Width-1:0] Func7MulDiv = 7'b0000001;

    // Exact ALU operation seen by execute
    typedef enum logic [AluOpWidth-1:0] {
        AluAnd = 5'd0,
        AluOr = 5'd1,
        AluAdd = 5'd2,
        AluXor = 5'd3,
        AluSub = 5'd4,
        AluSll = 5'd6,
        AluSrl = 5'd7,
        AluSra = 5'd8,
        AluSlt = 5'd9,
        AluSltu = 5'd10,
        AluMul = 5'd11,
        AluMulh = 5'd12,
        AluMulhsu = 5'd13,
        AluMulhu = 5'd14,
        AluDiv = 5'd15,
        AluDivu = 5'd16,
        AluRem = 5'd17,
        AluRemu = 5'd18,
        // Operand B straight through, used by LUI
        AluPassB = 5'd19
    } aluOpT;

    // Immediate layouts
    typedef enum logic [2:0] {
        ImmNone,
        ImmI,
        ImmS,
        ImmB,
        ImmU,
        ImmJ
    } immFmtT;

endpackage

`default_nettype wire

// ==== design/controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecoder import decodePkg::*;
(
    input wire instrT instr,
    output aluOpT aluOp,
    output logic aluSrcImm,
    output logic aluSrcPc,
    output logic memRead,
    output logic memWrite,
    output logic regWrite,
    output logic memToReg,
    output logic branch,
    output logic jump,
    output logic system,
    output logic illegal
);

    opcodeT opcode;
    funct3T funct3;
    logic [Funct7Width-1:0] funct7;

    // Instruction fields
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb
    begin
        // Defaults describe a harmless add
        aluOp = AluAdd;
        aluSrcImm = 1'b0;
        aluSrcPc = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        memToReg = 1'b0;
        branch = 1'b0;
        jump = 1'b0;
        system = 1'b0;
        illegal = 1'b0;

        // Every supported opcode ends in 11, so other lengths fall to default
        case (opcode)
            OpLui:
            begin
                aluOp = AluPassB;
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
            end
            OpAuipc:
            begin
                aluSrcImm = 1'b1;
                aluSrcPc = 1'b1;
                regWrite = 1'b1;
            end
            // Target is pc + imm, link written to rd
            OpJal:
            begin
                aluSrcImm = 1'b1;
                aluSrcPc = 1'b1;
                regWrite = 1'b1;
                jump = 1'b1;
            end
            OpJalr:
            begin
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
                jump = 1'b1;
                illegal = (funct3 != 3'b000);
            end
            OpBranch:
            begin
                branch = 1'b1;
                // Compare kind picked by func3
                case (funct3)
                    3'b000, 3'b001: aluOp = AluSub;
                    3'b100, 3'b101: aluOp = AluSlt;
                    3'b110, 3'b111: aluOp = AluSltu;
                    default: illegal = 1'b1;
                endcase
            end
            OpLoad:
            begin
                aluSrcImm = 1'b1;
                memRead = 1'b1;
                regWrite = 1'b1;
                memToReg = 1'b1;
                // lb, lh, lw, lbu, lhu only
                illegal = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
            end
            OpStore:
            begin
                aluSrcImm = 1'b1;
                memWrite = 1'b1;
                illegal = (funct3[2] || funct3 == 3'b011);
            end
            OpImm:
            begin
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
                case (funct3)
                    3'b000: aluOp = AluAdd;
                    3'b010: aluOp = AluSlt;
                    3'b011: aluOp = AluSltu;
                    3'b100: aluOp = AluXor;
                    3'b110: aluOp = AluOr;
                    3'b111: aluOp = AluAnd;
                    // Shift immediates carry func7 in the upper bits
                    3'b001:
                    begin
                        aluOp = AluSll;
                        illegal = (funct7 != Func7Base);
                    end
                    default:
                    begin
                        if (funct7 == Func7Base)
                            aluOp = AluSrl;
                        else if (funct7 == Func7Alt)
                            aluOp = AluSra;
                        else
                            illegal = 1'b1;
                    end
                endcase
            end
            OpReg:
            begin
                regWrite = 1'b1;
                case (funct7)
                    Func7Base:
                    begin
                        case (funct3)
                            3'b000: aluOp = AluAdd;
                            3'b001: aluOp = AluSll;
                            3'b010: aluOp = AluSlt;
                            3'b011: aluOp = AluSltu;
                            3'b100: aluOp = AluXor;
                            3'b101: aluOp = AluSrl;
                            3'b110: aluOp = AluOr;
                            default: aluOp = AluAnd;
                        endcase
                    end
                    // Only sub and sra use the alternate func7
                    Func7Alt:
                    begin
                        case (funct3)
                            3'b000: aluOp = AluSub;
                            3'b101: aluOp = AluSra;
                            default: illegal = 1'b1;
                        endcase
                    end
                    // M extension group
                    Func7MulDiv:
                    begin
                        case (funct3)
                            3'b000: aluOp = AluMul;
                            3'b001: aluOp = AluMulh;
                            3'b010: aluOp = AluMulhsu;
                            3'b011: aluOp = AluMulhu;
                            3'b100: aluOp = AluDiv;
                            3'b101: aluOp = AluDivu;
                            3'b110: aluOp = AluRem;
                            default: aluOp = AluRemu;
                        endcase
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OpSystem:
            begin
                // ecall has imm 0, ebreak imm 1; rd, rs1 and func3 all zero
                system = 1'b1;
                illegal = (instr[31:21] != '0) || (instr[19:7] != '0);
            end
            default: illegal = 1'b1;
        endcase

        // Illegal words must not touch state
        if (illegal)
        begin
            aluOp = AluAdd;
            aluSrcImm = 1'b0;
            aluSrcPc = 1'b0;
            memRead = 1'b0;
            memWrite = 1'b0;
            regWrite = 1'b0;
            memToReg = 1'b0;
            branch = 1'b0;
            jump = 1'b0;
            system = 1'b0;
        end
    end

    // Load and store are exclusive for every word
    always_comb
    begin
        assert (!(memRead && memWrite))
            else $error("memRead and memWrite both set for %h", instr);
    end

endmodule

`default_nettype wire

// ==== design/immediateGenerator.sv ====
`timescale 1ns/1ps
`default_nettype none

module immediateGenerator import decodePkg::*;
(
    input wire instrT instr,
    output wordT imm
);

    opcodeT opcode;
    immFmtT fmt;

    assign opcode = instr[6:0];

    // Format lookup from the opcode
    always_comb
    begin
        case (opcode)
            OpImm, OpLoad, OpJalr, OpSystem: fmt = ImmI;
            OpStore: fmt = ImmS;
            OpBranch: fmt = ImmB;
            OpLui, OpAuipc: fmt = ImmU;
            OpJal: fmt = ImmJ;
            // Register ops and unknown words carry no immediate
            default: fmt = ImmNone;
        endcase
    end

    // Sign bit is always instr[31]
    always_comb
    begin
        case (fmt)
            ImmI:
                imm = {{20{instr[31]}}, instr[31:20]};
            ImmS:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offset in halfwords, bit 0 implied zero
            ImmB:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            // Upper 20 bits, low 12 cleared
            ImmU:
                imm = {instr[31:12], 12'b0};
            ImmJ:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/decodeIssue.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeIssue import decodePkg::*;
(
    input wire clk,
    input wire rst,
    input wire inValid,
    output logic inReady,
    input wire instrT instr,
    // Results of the two decoders
    input wire aluOpT decAluOp,
    input wire decAluSrcImm,
    input wire decAluSrcPc,
    input wire decMemRead,
    input wire decMemWrite,
    input wire decRegWrite,
    input wire decMemToReg,
    input wire decBranch,
    input wire decJump,
    input wire decSystem,
    input wire decIllegal,
    input wire wordT decImm,
    output logic outValid,
    input wire outReady,
    // Registered bundle
    output regIdxT rd,
    output regIdxT rs1,
    output regIdxT rs2,
    output funct3T funct3,
    output wordT imm,
    output aluOpT aluOp,
    output logic aluSrcImm,
    output logic aluSrcPc,
    output logic memRead,
    output logic memWrite,
    output logic regWrite,
    output logic memToReg,
    output logic branch,
    output logic jump,
    output logic system,
    output logic illegal
);

    logic accept;

    // Slot frees up when empty or draining this edge
    assign inReady = !outValid || outReady;
    assign accept = inValid && inReady;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            outValid <= 1'b0;
        else if (inReady)
            outValid <= inValid;
    end

    // Controls cleared by reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            aluOp <= AluAnd;
            aluSrcImm <= 1'b0;
            aluSrcPc <= 1'b0;
            memRead <= 1'b0;
            memWrite <= 1'b0;
            regWrite <= 1'b0;
            memToReg <= 1'b0;
            branch <= 1'b0;
            jump <= 1'b0;
            system <= 1'b0;
            illegal <= 1'b0;
        end
        else if (accept)
        begin
            aluOp <= decAluOp;
            aluSrcImm <= decAluSrcImm;
            aluSrcPc <= decAluSrcPc;
            memRead <= decMemRead;
            memWrite <= decMemWrite;
            regWrite <= decRegWrite;
            memToReg <= decMemToReg;
            branch <= decBranch;
            jump <= decJump;
            system <= decSystem;
            illegal <= decIllegal;
        end
    end

    // Payload fields, straight from the instruction
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rd <= instr[11:7];
            rs1 <= instr[19:15];
            rs2 <= instr[24:20];
            funct3 <= instr[14:12];
            imm <= decImm;
        end
    end

    // A stalled bundle stays put until taken
    assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable({rd, rs1, rs2, funct3, imm,
            aluOp, aluSrcImm, aluSrcPc, memRead, memWrite, regWrite, memToReg,
            branch, jump, system, illegal})))
        else $error("bundle changed while stalled");

    // Nothing offered on the first edge out of reset
    assert property (@(posedge clk) $past(rst) |-> !outValid)
        else $error("outValid high right after reset");

endmodule

`default_nettype wire

// ==== design/rvDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvDecode import decodePkg::*;
(
    input wire clk,
    input wire rst,
    input wire inValid,
    output logic inReady,
    input wire instrT inInstr,
    output logic outValid,
    input wire outReady,
    output regIdxT rd,
    output regIdxT rs1,
    output regIdxT rs2,
    output funct3T funct3,
    output wordT imm,
    output aluOpT aluOp,
    output logic aluSrcImm,
    output logic aluSrcPc,
    output logic memRead,
    output logic memWrite,
    output logic regWrite,
    output logic memToReg,
    output logic branch,
    output logic jump,
    output logic system,
    output logic illegal
);

    // Combinational decoder results
    aluOpT decAluOp;
    logic decAluSrcImm;
    logic decAluSrcPc;
    logic decMemRead;
    logic decMemWrite;
    logic decRegWrite;
    logic decMemToReg;
    logic decBranch;
    logic decJump;
    logic decSystem;
    logic decIllegal;
    wordT decImm;

    // Control path
    controlDecoder i_controlDecoder (
        .instr(inInstr),
        .aluOp(decAluOp),
        .aluSrcImm(decAluSrcImm),
        .aluSrcPc(decAluSrcPc),
        .memRead(decMemRead),
        .memWrite(decMemWrite),
        .regWrite(decRegWrite),
        .memToReg(decMemToReg),
        .branch(decBranch),
        .jump(decJump),
        .system(decSystem),
        .illegal(decIllegal)
    );

    // Immediate path, in parallel
    immediateGenerator i_immediateGenerator (
        .instr(inInstr),
        .imm(decImm)
    );

    // One-entry issue register
    decodeIssue i_decodeIssue (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .instr(inInstr),
        .decAluOp(decAluOp),
        .decAluSrcImm(decAluSrcImm),
        .decAluSrcPc(decAluSrcPc),
        .decMemRead(decMemRead),
        .decMemWrite(decMemWrite),
        .decRegWrite(decRegWrite),
        .decMemToReg(decMemToReg),
        .decBranch(decBranch),
        .decJump(decJump),
        .decSystem(decSystem),
        .decIllegal(decIllegal),
        .decImm(decImm),
        .outValid(outValid),
        .outReady(outReady),
        .rd(rd),
        .rs1(rs1),
        .rs2(rs2),
        .funct3(funct3),
        .imm(imm),
        .aluOp(aluOp),
        .aluSrcImm(aluSrcImm),
        .aluSrcPc(aluSrcPc),
        .memRead(memRead),
        .memWrite(memWrite),
        .regWrite(regWrite),
        .memToReg(memToReg),
        .branch(branch),
        .jump(jump),
        .system(system),
        .illegal(illegal)
    );

endmodule

`default_nettype wire

// ==== sim/decodeRef.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Everything the execute stage receives for one instruction
typedef struct packed {
    regIdxT rd;
    regIdxT rs1;
    regIdxT rs2;
    funct3T funct3;
    wordT imm;
    aluOpT aluOp;
    logic aluSrcImm;
    logic aluSrcPc;
    logic memRead;
    logic memWrite;
    logic regWrite;
    logic memToReg;
    logic branch;
    logic jump;
    logic system;
    logic illegal;
} bundleT;

// Sign extend a field held in the low bits
function automatic wordT sext(input wordT v, input int bits);
    return wordT'($signed(v << (32 - bits)) >>> (32 - bits));
endfunction

// Base integer operations, alt picks sub and sra
function automatic aluOpT baseAlu(input funct3T f3, input logic alt);
    case (f3)
        3'b000: return alt ? AluSub : AluAdd;
        3'b001: return AluSll;
        3'b010: return AluSlt;
        3'b011: return AluSltu;
        3'b100: return AluXor;
        3'b101: return alt ? AluSra : AluSrl;
        3'b110: return AluOr;
        default: return AluAnd;
    endcase
endfunction

// M extension, in func3 order
function automatic aluOpT mulDivAlu(input funct3T f3)
;
    case (f3)
        3'b000: return AluMul;
        3'b001: return AluMulh;
        3'b010: return AluMulhsu;
        3'b011: return AluMulhu;
        3'b100: return AluDiv;
        3'b101: return AluDivu;
        3'b110: return AluRem;
        default: return AluRemu;
    endcase
endfunction

// Expected bundle for one instruction word
function automatic bundleT refDecode(input instrT w);
    bundleT b;
    funct3T f3;
    logic [6:0] f7;
    logic bad;
    f3 = w[14:12];
    f7 = w[31:25];
    bad = 1'b0;
    b = '0;
    b.rd = w[11:7];
    b.rs1 = w[19:15];
    b.rs2 = w[24:20];
    b.funct3 = f3;
    b.aluOp = AluAdd;
    case (opcodeT'(w[6:0]))
        OpLui:
        begin
            {b.aluSrcImm, b.regWrite} = 2'b11;
            b.aluOp = AluPassB;
            b.imm = {w[31:12], 12'h000};
        end
        OpAuipc:
        begin
            {b.aluSrcImm, b.aluSrcPc, b.regWrite} = 3'b111;
            b.imm = {w[31:12], 12'h000};
        end
        OpJal:
        begin
            {b.aluSrcImm, b.aluSrcPc, b.regWrite, b.jump} = 4'b1111;
            b.imm = sext(wordT'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
        end
        OpJalr:
        begin
            {b.aluSrcImm, b.regWrite, b.jump} = 3'b111;
            bad = (f3 != 3'b000);
            b.imm = sext(wordT'(w[31:20]), 12);
        end
        OpBranch:
        begin
            b.branch = 1'b1;
            // beq/bne subtract, the rest compare
            b.aluOp = f3[2] ? (f3[1] ? AluSltu : AluSlt) : AluSub;
            bad = (f3[2:1] == 2'b01);
            b.imm = sext(wordT'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
        end
        OpLoad:
        begin
            {b.aluSrcImm, b.memRead, b.regWrite, b.memToReg} = 4'b1111;
            bad = !(f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
            b.imm = sext(wordT'(w[31:20]), 12);
        end
        OpStore:
        begin
            {b.aluSrcImm, b.memWrite} = 2'b11;
            // sb, sh, sw only
            bad = (f3 > 3'b010);
            b.imm = sext(wordT'({w[31:25], w[11:7]}), 12);
        end
        OpImm:
        begin
            {b.aluSrcImm, b.regWrite} = 2'b11;
            b.aluOp = baseAlu(f3, f3 == 3'b101 && f7 == Func7Alt);
            if (f3 == 3'b001)
                bad = (f7 != Func7Base);
            else if (f3 == 3'b101)
                bad = !(f7 inside {Func7Base, Func7Alt});
            b.imm = sext(wordT'(w[31:20]), 12);
        end
        OpReg:
        begin
            b.regWrite = 1'b1;
            if (f7 == Func7MulDiv)
                b.aluOp = mulDivAlu(f3);
            else
                b.aluOp = baseAlu(f3, f7 == Func7Alt);
            // Alt func7 is only sub and sra
            bad = !((f7 == Func7Base) || (f7 == Func7MulDiv)
                || (f7 == Func7Alt && (f3 == 3'b000 || f3 == 3'b101)));
        end
        OpSystem:
        begin
            b.system = 1'b1;
            // Only bit 20 may differ, ecall versus ebreak
            bad = ({w[31:21], w[19:7]} != '0);
            b.imm = sext(wordT'(w[31:20]), 12);
        end
        default:
            bad = 1'b1;
    endcase
    // Illegal words keep fields and imm, lose every control
    if (bad)
    begin
        b.aluOp = AluAdd;
        {b.aluSrcImm, b.aluSrcPc, b.memRead, b.memWrite, b.regWrite} = 5'b0;
        {b.memToReg, b.branch, b.jump, b.system} = 4'b0;
        b.illegal = 1'b1;
    end
    return b;
endfunction

// Instruction builders, register fields taken from r
function automatic instrT rType(input logic [6:0] f7, input funct3T f3, input instrT r);
    return {f7, r[24:20], r[19:15], f3, r[11:7], OpReg};
endfunction

function automatic instrT iType(input logic [11:0] i, input funct3T f3, input opcodeT op,
                                input instrT r);
    return {i, r[19:15], f3, r[11:7], op};
endfunction

function automatic instrT sType(input logic [11:0] i, input funct3T f3, input instrT r);
    return {i[11:5], r[24:20], r[19:15], f3, i[4:0], OpStore};
endfunction

// Offset bit 0 is dropped
function automatic instrT bType(input logic [12:0] i, input funct3T f3, input instrT r);
    return {i[12], i[10:5], r[24:20], r[19:15], f3, i[4:1], i[11], OpBranch};
endfunction

function automatic instrT uType(input logic [19:0] i, input opcodeT op, input instrT r);
    return {i, r[11:7], op};
endfunction

function automatic instrT jType(input logic [20:0] i, input instrT r);
    return {i[20], i[10:1], i[11], i[19:12], r[11:7], OpJal};
endfunction

// Random word with a known opcode and mostly legal func7
function automatic instrT patternWord(input instrT r, input logic [31:0] s);
    instrT w;
    w = r;
    case (s[4:1])
        4'd0: w[6:0] = OpLui;
        4'd1: w[6:0] = OpAuipc;
        4'd2: w[6:0] = OpJal;
        4'd3: w[6:0] = OpJalr;
        4'd4: w[6:0] = OpBranch;
        4'd5: w[6:0] = OpLoad;
        4'd6: w[6:0] = OpStore;
        4'd7: w[6:0] = OpImm;
        4'd8: w[6:0] = OpSystem;
        // Leftover codes land on register ops
        default: w[6:0] = OpReg;
    endcase
    case (s[6:5])
        2'd0: w[31:25] = Func7Base;
        2'd1: w[31:25] = Func7Alt;
        2'd2: w[31:25] = Func7MulDiv;
        default: w[31:25] = r[31:25];
    endcase
    return w;
endfunction

`endif

// ==== sim/decodeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeTb import decodePkg::*; ();

    localparam int Period = 100;
    localparam int ResetCycles = 10;
    localparam int NumDirected = 80;
    localparam int NumRandom = 400;
    localparam int NumStream = 64;
    // Rough cycle budget of two per instruction
    localparam int TestCycles = 2 * (NumDirected + NumRandom + NumStream);

    logic clk = 1'b0;
    logic rst;
    logic inValid;
    logic inReady;
    instrT inInstr;
    logic outValid;
    logic outReady;
    regIdxT rd;
    regIdxT rs1;
    regIdxT rs2;
    funct3T funct3;
    wordT imm;
    aluOpT aluOp;
    logic aluSrcImm;
    logic aluSrcPc;
    logic memRead;
    logic memWrite;
    logic regWrite;
    logic memToReg;
    logic branch;
    logic jump;
    logic system;
    logic illegal;

    `include "decodeRef.svh"

    // Expected bundles and test names in issue order
    bundleT expQ[$];
    string nameQ[$];
    bundleT seen;
    bundleT held;
    logic [31:0] rng = 32'd9;
    // Separate stream for the downstream side
    logic [31:0] readyRng = 32'd9;
    logic randomReady;
    logic readyMode;
    logic streaming;
    logic wasStalled = 1'b0;
    logic wasAccepted = 1'b0;

    always #(Period / 2) clk = ~clk;

    rvDecode i_dut (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .inInstr(inInstr),
        .outValid(outValid),
        .outReady(outReady),
        .rd(rd),
        .rs1(rs1),
        .rs2(rs2),
        .funct3(funct3),
        .imm(imm),
        .aluOp(aluOp),
        .aluSrcImm(aluSrcImm),
        .aluSrcPc(aluSrcPc),
        .memRead(memRead),
        .memWrite(memWrite),
        .regWrite(regWrite),
        .memToReg(memToReg),
        .branch(branch),
        .jump(jump),
        .system(system),
        .illegal(illegal)
    );

    assign seen = {rd, rs1, rs2, funct3, imm, aluOp, aluSrcImm, aluSrcPc, memRead,
                   memWrite, regWrite, memToReg, branch, jump, system, illegal};

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input string name, input wordT exp, input wordT act);
        if (exp !== act)
            stopRun($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic checkIdx(input string name, input regIdxT exp, input regIdxT act);
        if (exp !== act)
            stopRun($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic checkAluOp(input string name, input aluOpT exp, input aluOpT act);
        if (exp !== act)
            stopRun($sformatf("Fail %s: expected %s (%0d), actual %s (%0d)", name,
                              exp.name(), exp, act.name(), act));
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (exp !== act)
            stopRun($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    // Every field of the bundle on the DUT outputs
    task automatic verifyBundle(input string test, input bundleT e);
        checkIdx({test, " rd"}, e.rd, rd);
        checkIdx({test, " rs1"}, e.rs1, rs1);
        checkIdx({test, " rs2"}, e.rs2, rs2);
        checkIdx({test, " funct3"}, regIdxT'(e.funct3), regIdxT'(funct3));
        checkWord({test, " imm"}, e.imm, imm);
        checkAluOp({test, " aluOp"}, e.aluOp, aluOp);
        checkFlag({test, " aluSrcImm"}, e.aluSrcImm, aluSrcImm);
        checkFlag({test, " aluSrcPc"}, e.aluSrcPc, aluSrcPc);
        checkFlag({test, " memRead"}, e.memRead, memRead);
        checkFlag({test, " memWrite"}, e.memWrite, memWrite);
        checkFlag({test, " regWrite"}, e.regWrite, regWrite);
        checkFlag({test, " memToReg"}, e.memToReg, memToReg);
        checkFlag({test, " branch"}, e.branch, branch);
        checkFlag({test, " jump"}, e.jump, jump);
        checkFlag({test, " system"}, e.system, system);
        checkFlag({test, " illegal"}, e.illegal, illegal);
    endtask

    // Offer one word until taken with an optional idle cycle first
    task automatic sendInstr(input instrT w, input string name, input logic mayIdle);
        if (mayIdle)
        begin
            rng = xorshift(rng);
            if (rng[2:0] == 3'd0)
            begin
                inValid = 1'b0;
                @(posedge clk);
                #1;
            end
        end
        inValid = 1'b1;
        inInstr = w;
        // Inputs settle before the falling edge
        do
            @(negedge clk);
        while (!inReady);
        expQ.push_back(refDecode(w));
        nameQ.push_back(name);
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        inValid = 1'b0;
        // Pops happen at falling edges and are settled by the rising edge
        while (expQ.size() != 0)
            @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    // Downstream back-pressure with the mode taken at the edge
    always @(posedge clk)
    begin
        readyMode = randomReady;
        #1;
        if (readyMode)
        begin
            readyRng = xorshift(readyRng);
            outReady = (readyRng[1:0] != 2'b00);
        end
        else
            outReady = 1'b1;
    end

    // Checker samples at the falling edge where outputs are stable
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (wasStalled)
            begin
                if (!outValid)
                    stopRun("outValid dropped while the bundle was stalled");
                verifyBundle("stall hold", held);
            end
            if (wasAccepted && !outValid)
                stopRun("accepted instruction did not appear one cycle later");
            // Streaming means one in and one out per cycle
            if (streaming && inValid && !inReady)
                stopRun("inReady low while streaming with outReady high");
            if (outValid && outReady)
            begin
                if (expQ.size() == 0)
                    stopRun("a bundle left the DUT with nothing expected");
                else
                    verifyBundle(nameQ.pop_front(), expQ.pop_front());
            end
            wasStalled = outValid && !outReady;
            held = seen;
            wasAccepted = inValid && inReady;
        end
    end

    initial
    begin
        #(Period * (ResetCycles + 4 * TestCycles));
        stopRun("timeout: the DUT stopped moving instructions");
    end

    initial
    begin
        instrT w;
        funct3T g;
        rst = 1'b1;
        inValid = 1'b0;
        inInstr = '0;
        outReady = 1'b0;
        randomReady = 1'b0;
        streaming = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkFlag("reset outValid", 1'b0, outValid);
        checkFlag("reset inReady", 1'b1, inReady);
        @(posedge clk);
        #1;
        randomReady = 1'b1;

        // Every func3 of every func3-driven class
        for (int f = 0; f < 8; f++)
        begin
            g = funct3T'(f);
            rng = xorshift(rng);
            sendInstr(bType(13'h0a4, g, rng), $sformatf("branch %0d", f), 1'b0);
            sendInstr(iType(12'h7f0, g, OpLoad, rng), $sformatf("load %0d", f), 1'b0);
            sendInstr(sType(12'h018, g, rng), $sformatf("store %0d", f), 1'b0);
            sendInstr(iType(12'h01d, g, OpImm, rng), $sformatf("op-imm %0d", f), 1'b0);
            sendInstr(rType(Func7Base, g, rng), $sformatf("op %0d", f), 1'b0);
            sendInstr(rType(Func7MulDiv, g, rng), $sformatf("muldiv %0d", f), 1'b0);
        end
        rng = xorshift(rng);
        sendInstr(uType(20'h12345, OpLui, rng), "lui", 1'b0);
        sendInstr(uType(20'habcde, OpAuipc, rng), "auipc", 1'b0);
        sendInstr(jType(21'h00_0ffc, rng), "jal", 1'b0);
        sendInstr(iType(12'h044, 3'b000, OpJalr, rng), "jalr", 1'b0);
        sendInstr(iType(12'h044, 3'b010, OpJalr, rng), "jalr bad func3", 1'b0);
        sendInstr(rType(Func7Alt, 3'b000, rng), "sub", 1'b0);
        sendInstr(rType(Func7Alt, 3'b101, rng), "sra", 1'b0);
        sendInstr(iType({Func7Alt, 5'd3}, 3'b101, OpImm, rng), "srai", 1'b0);
        sendInstr(iType({Func7Alt, 5'd3}, 3'b001, OpImm, rng), "slli bad func7", 1'b0);
        sendInstr(iType(12'h000, 3'b000, OpSystem, '0), "ecall", 1'b0);
        sendInstr(iType(12'h001, 3'b000, OpSystem, '0), "ebreak", 1'b0);
        sendInstr(iType(12'h002, 3'b000, OpSystem, '0), "system bad imm", 1'b0);
        sendInstr(32'h0000_0000, "zero word", 1'b0);
        sendInstr(iType(12'h001, 3'b000, 7'b0010001, rng), "low bits 01", 1'b0);
        sendInstr(rType(7'b1000000, 3'b000, rng), "op bad func7", 1'b0);

        // Immediate edges with all ones and only the sign bit
        sendInstr(iType(12'hfff, 3'b000, OpImm, rng), "imm I ones", 1'b0);
        sendInstr(iType(12'h800, 3'b000, OpImm, rng), "imm I sign", 1'b0);
        sendInstr(sType(12'hfff, 3'b010, rng), "imm S ones", 1'b0);
        sendInstr(sType(12'h800, 3'b010, rng), "imm S sign", 1'b0);
        sendInstr(bType(13'h1ffe, 3'b000, rng), "imm B ones", 1'b0);
        sendInstr(bType(13'h1000, 3'b001, rng), "imm B sign", 1'b0);
        sendInstr(uType(20'hfffff, OpAuipc, rng), "imm U ones", 1'b0);
        sendInstr(uType(20'h80000, OpLui, rng), "imm U sign", 1'b0);
        sendInstr(jType(21'h1ffffe, rng), "imm J ones", 1'b0);
        sendInstr(jType(21'h100000, rng), "imm J sign", 1'b0);

        // Half pattern words and half raw words
        for (int n = 0; n < NumRandom; n++)
        begin
            rng = xorshift(rng);
            w = rng;
            rng = xorshift(rng);
            if (rng[0])
                w = patternWord(w, rng);
            sendInstr(w, $sformatf("random %0d", n), 1'b1);
        end

        // Back-to-back with no back-pressure
        randomReady = 1'b0;
        drain();
        streaming = 1'b1;
        for (int n = 0; n < NumStream; n++)
        begin
            rng = xorshift(rng);
            sendInstr(patternWord(rng, xorshift(rng)), $sformatf("stream %0d", n), 1'b0);
        end
        drain();
        streaming = 1'b0;
        repeat (2) @(posedge clk);

        if (expQ.size() != 0 || outValid)
            stopRun("bundles were left in the DUT at the end");
        else
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+sim
design/decodePkg.sv
design/controlDecoder.sv
design/immediateGenerator.sv
design/decodeIssue.sv
design/rvDecode.sv
sim/decodeTb.sv

// ==== Makefile ====
# Verilator flow for the decode stage testbench
TOP := decodeTb
OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ) -f files.f
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log
